// ==== Makefile ====
TOP := tb_pcie_tx_bridge
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module pcie_tx_bridge

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
+incdir+src
src/pcie_tx_axi_pkg.sv
src/pcie_tx_trn_pkg.sv
src/tx_ingress_buffer.sv
src/tx_link_flush.sv
src/tx_trn_framer.sv
src/pcie_tx_bridge.sv
tb/tb_pcie_tx_bridge.sv

// ==== src/pcie_tx_axi_pkg.sv ====
`default_nettype none
`include "pcie_tx_cfg.svh"

package pcie_tx_axi_pkg;

  // Width of the AXI tuser sideband word
  localparam int unsigned tuser_width = 4;

  // Bit positions of the tuser flags
  localparam int unsigned tuser_ecrc_gen = 0;
  localparam int unsigned tuser_err_fwd = 1;
  localparam int unsigned tuser_str = 2;
  localparam int unsigned tuser_src_dsc = 3;

  // Number of DWORDs in one data word
  localparam int unsigned axi_dw_count = `PCIE_TX_DATA_WIDTH / 32;

  // Index of the highest DWORD whose top byte is enabled
  function automatic int unsigned keep_last_dw(input logic [`PCIE_TX_KEEP_WIDTH-1:0] keep);
    int unsigned last;
    last = 0;
    // Scan upward so the highest enabled DWORD wins
    for (int unsigned i = 0; i < axi_dw_count; i++) begin
      if (keep[4*i+3]) begin
        last = i;
      end
    end
    return last;
  endfunction

endpackage

`default_nettype wire

// ==== src/pcie_tx_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pcie_tx_cfg.svh"

module pcie_tx_bridge
  import pcie_tx_axi_pkg::*;
(
  input  wire                            user_clk,
  input  wire                            user_rst,
  input  wire  [`PCIE_TX_DATA_WIDTH-1:0] s_axis_tx_tdata,
  input  wire  [`PCIE_TX_KEEP_WIDTH-1:0] s_axis_tx_tkeep,
  input  wire                            s_axis_tx_tlast,
  input  wire          [tuser_width-1:0] s_axis_tx_tuser,
  input  wire                            s_axis_tx_tvalid,
  output logic                           s_axis_tx_tready,
  output logic [`PCIE_TX_DATA_WIDTH-1:0] trn_td,
  output logic                           trn_tsof,
  output logic                           trn_teof,
  output logic  [`PCIE_TX_REM_WIDTH-1:0] trn_trem,
  output logic                           trn_tsrc_rdy,
  input  wire                            trn_tdst_rdy,
  output logic                           trn_tsrc_dsc,
  output logic                           trn_terrfwd,
  output logic                           trn_tstr,
  output logic                           trn_tecrc_gen,
  input  wire                            trn_lnk_up
);

  // Registered beat handed to the framer
  logic [`PCIE_TX_DATA_WIDTH-1:0] stage_data;
  logic [`PCIE_TX_KEEP_WIDTH-1:0] stage_keep;
  logic                           stage_last;
  logic         [tuser_width-1:0] stage_user;

  logic flush_axi;
  logic disable_trn;
  logic axi_beat;
  logic axi_last;

  // Beat accepted from the user this cycle
  assign axi_beat = s_axis_tx_tvalid && s_axis_tx_tready;
  assign axi_last = s_axis_tx_tlast;

  tx_ingress_buffer u_ingress (
    .user_clk         (user_clk),
    .user_rst         (user_rst),
    .s_axis_tx_tdata  (s_axis_tx_tdata),
    .s_axis_tx_tkeep  (s_axis_tx_tkeep),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tuser  (s_axis_tx_tuser),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tready (s_axis_tx_tready),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_lnk_up       (trn_lnk_up),
    .flush_axi        (flush_axi),
    .disable_trn      (disable_trn),
    .stage_data       (stage_data),
    .stage_keep       (stage_keep),
    .stage_last       (stage_last),
    .stage_user       (stage_user),
    .trn_tsrc_rdy     (trn_tsrc_rdy)
  );

  tx_link_flush u_flush (
    .user_clk         (user_clk),
    .user_rst         (user_rst),
    .axi_beat         (axi_beat),
    .axi_last         (axi_last),
    .trn_lnk_up       (trn_lnk_up),
    .s_axis_tx_tready (s_axis_tx_tready),
    .flush_axi        (flush_axi),
    .disable_trn      (disable_trn)
  );

  tx_trn_framer u_framer (
    .user_clk      (user_clk),
    .user_rst      (user_rst),
    .stage_data    (stage_data),
    .stage_keep    (stage_keep),
    .stage_last    (stage_last),
    .stage_user    (stage_user),
    .trn_tsrc_rdy  (trn_tsrc_rdy),
    .trn_tdst_rdy  (trn_tdst_rdy),
    .trn_lnk_up    (trn_lnk_up),
    .trn_td        (trn_td),
    .trn_tsof      (trn_tsof),
    .trn_teof      (trn_teof),
    .trn_trem      (trn_trem),
    .trn_tecrc_gen (trn_tecrc_gen),
    .trn_terrfwd   (trn_terrfwd),
    .trn_tstr      (trn_tstr),
    .trn_tsrc_dsc  (trn_tsrc_dsc)
  );

endmodule

`default_nettype wire

// ==== src/pcie_tx_cfg.svh ====
`ifndef PCIE_TX_CFG_SVH
`define PCIE_TX_CFG_SVH

// Data width shared by the AXI and TRN transmit buses
// Supported values are 128, 64 and 32
`define PCIE_TX_DATA_WIDTH 128

// One keep bit per byte of data
`define PCIE_TX_KEEP_WIDTH (`PCIE_TX_DATA_WIDTH / 8)

// Remainder selects a DWORD at 128 bits
// Narrower buses only need one bit
`define PCIE_TX_REM_WIDTH ((`PCIE_TX_DATA_WIDTH == 128) ? 2 : 1)

`endif

// ==== src/pcie_tx_trn_pkg.sv ====
`default_nettype none
`include "pcie_tx_cfg.svh"

package pcie_tx_trn_pkg;

  import pcie_tx_axi_pkg::*;

  // TRN carries DWORD 0 in the top lane
  // AXI carries it in the bottom lane
  // 128 bits maps AXI DW3..DW0 onto TRN DW0..DW3
  // 32 bits has a single lane so nothing moves
  function automatic logic [`PCIE_TX_DATA_WIDTH-1:0] trn_dw_swap(
    input logic [`PCIE_TX_DATA_WIDTH-1:0] data
  );
    logic [`PCIE_TX_DATA_WIDTH-1:0] swapped;
    swapped = '0;
    for (int unsigned i = 0; i < axi_dw_count; i++) begin
      swapped[32*i +: 32] = data[32*(axi_dw_count-1-i) +: 32];
    end
    return swapped;
  endfunction

  // Remainder encoding by bus width
  //   128 bits  number of valid DWORDs above D0 (0 to 3)
  //   64 bits   set when the upper DWORD carries data
  //   32 bits   always zero
  function automatic logic [`PCIE_TX_REM_WIDTH-1:0] keep_to_trem(
    input logic [`PCIE_TX_KEEP_WIDTH-1:0] keep
  );
    logic [`PCIE_TX_REM_WIDTH-1:0] trem;
    int unsigned last;
    last = keep_last_dw(keep);
    trem = '0;
    if (`PCIE_TX_DATA_WIDTH == 128) begin
      trem = `PCIE_TX_REM_WIDTH'(last);
    end else if (`PCIE_TX_DATA_WIDTH == 64) begin
      // Same as keep bit 7
      trem = `PCIE_TX_REM_WIDTH'(last == 1);
    end
    return trem;
  endfunction

endpackage

`default_nettype wire

// ==== src/tx_ingress_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pcie_tx_cfg.svh"

module tx_ingress_buffer
  import pcie_tx_axi_pkg::*;
(
  input  wire                            user_clk,
  input  wire                            user_rst,
  input  wire  [`PCIE_TX_DATA_WIDTH-1:0] s_axis_tx_tdata,
  input  wire  [`PCIE_TX_KEEP_WIDTH-1:0] s_axis_tx_tkeep,
  input  wire                            s_axis_tx_tlast,
  input  wire          [tuser_width-1:0] s_axis_tx_tuser,
  input  wire                            s_axis_tx_tvalid,
  output logic                           s_axis_tx_tready,
  input  wire                            trn_tdst_rdy,
  input  wire                            trn_lnk_up,
  input  wire                            flush_axi,
  input  wire                            disable_trn,
  output logic [`PCIE_TX_DATA_WIDTH-1:0] stage_data,
  output logic [`PCIE_TX_KEEP_WIDTH-1:0] stage_keep,
  output logic                           stage_last,
  output logic         [tuser_width-1:0] stage_user,
  output logic                           trn_tsrc_rdy
);

  // Previous value buffer
  logic [`PCIE_TX_DATA_WIDTH-1:0] prev_data;
  logic [`PCIE_TX_KEEP_WIDTH-1:0] prev_keep;
  logic                           prev_last;
  logic         [tuser_width-1:0] prev_user;
  logic                           prev_valid;

  logic stage_valid;
  logic data_hold;
  logic data_prev;
  logic axi_end;

  // Block is stalling a presented beat
  assign data_hold = trn_tsrc_rdy && !trn_tdst_rdy;
  assign axi_end = s_axis_tx_tvalid && s_axis_tx_tready && s_axis_tx_tlast;

  // Nothing goes to the block while it is disabled
  assign trn_tsrc_rdy = stage_valid && !disable_trn;

  // Capture whatever is on the bus while tready is high
  // A beat taken during a stall waits here
  always_ff @(posedge user_clk) begin
    if (s_axis_tx_tready) begin
      prev_data <= s_axis_tx_tdata;
      prev_keep <= s_axis_tx_tkeep;
      prev_last <= s_axis_tx_tlast;
      prev_user <= s_axis_tx_tuser;
    end
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      prev_valid <= 1'b0;
    end else if (!trn_lnk_up || flush_axi) begin
      // Dropped packets never replay
      prev_valid <= 1'b0;
    end else if (s_axis_tx_tready) begin
      prev_valid <= s_axis_tx_tvalid;
    end
  end

  // One cycle after any hold the buffered beat goes next
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      data_prev <= 1'b0;
    end else begin
      data_prev <= data_hold;
    end
  end

  // Stage payload with HOLD / PREVIOUS / CURRENT selection
  always_ff @(posedge user_clk) begin
    if (!data_hold) begin
      if (data_prev) begin
        stage_data <= prev_data;
        stage_keep <= prev_keep;
        stage_last <= prev_last;
        stage_user <= prev_user;
      end else begin
        stage_data <= s_axis_tx_tdata;
        stage_keep <= s_axis_tx_tkeep;
        stage_last <= s_axis_tx_tlast;
        stage_user <= s_axis_tx_tuser;
      end
    end
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      stage_valid <= 1'b0;
    end else if (!trn_lnk_up || flush_axi) begin
      stage_valid <= 1'b0;
    end else if (!data_hold) begin
      // Current beat counts only when it was actually accepted
      stage_valid <= data_prev ? prev_valid : (s_axis_tx_tvalid && s_axis_tx_tready);
    end
  end

  // Registered tready follows the block one cycle late
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      s_axis_tx_tready <= 1'b0;
    end else if (flush_axi && !axi_end) begin
      // Drain the rest of a dropped packet
      s_axis_tx_tready <= 1'b1;
    end else if (trn_lnk_up) begin
      s_axis_tx_tready <= trn_tdst_rdy || !trn_tsrc_rdy;
    end else begin
      // Link down with nothing to drain
      s_axis_tx_tready <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/tx_link_flush.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_link_flush (
  input  wire  user_clk,
  input  wire  user_rst,
  input  wire  axi_beat,
  input  wire  axi_last,
  input  wire  trn_lnk_up,
  input  wire  s_axis_tx_tready,
  output logic flush_axi,
  output logic disable_trn
);

  logic axi_in_packet;
  logic axi_end;

  assign axi_end = axi_beat && axi_last;

  // AXI side packet tracking
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      axi_in_packet <= 1'b0;
    end else if (axi_beat) begin
      axi_in_packet <= !axi_last;
    end
  end

  // Link lost mid packet so the remainder gets drained and dropped
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      flush_axi <= 1'b0;
    end else if (axi_in_packet && !trn_lnk_up && !axi_end) begin
      flush_axi <= 1'b1;
    end else if (axi_end) begin
      flush_axi <= 1'b0;
    end
  end

  // TRN stays off from link loss until the drain is over
  // Waiting for tready lets the previous value buffer refill first
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      disable_trn <= 1'b1;
    end else if (!trn_lnk_up) begin
      disable_trn <= 1'b1;
    end else if (!flush_axi && s_axis_tx_tready) begin
      disable_trn <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/tx_trn_framer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pcie_tx_cfg.svh"

module tx_trn_framer
  import pcie_tx_axi_pkg::*;
  import pcie_tx_trn_pkg::*;
(
  input  wire                            user_clk,
  input  wire                            user_rst,
  input  wire  [`PCIE_TX_DATA_WIDTH-1:0] stage_data,
  input  wire  [`PCIE_TX_KEEP_WIDTH-1:0] stage_keep,
  input  wire                            stage_last,
  input  wire          [tuser_width-1:0] stage_user,
  input  wire                            trn_tsrc_rdy,
  input  wire                            trn_tdst_rdy,
  input  wire                            trn_lnk_up,
  output logic [`PCIE_TX_DATA_WIDTH-1:0] trn_td,
  output logic                           trn_tsof,
  output logic                           trn_teof,
  output logic  [`PCIE_TX_REM_WIDTH-1:0] trn_trem,
  output logic                           trn_tecrc_gen,
  output logic                           trn_terrfwd,
  output logic                           trn_tstr,
  output logic                           trn_tsrc_dsc
);

  logic trn_in_packet;
  logic trn_beat;

  // Completing edge on the TRN side
  assign trn_beat = trn_tsrc_rdy && trn_tdst_rdy;

  // Inside a packet after a non-last beat completes
  // Leaves on eof, or at once when the link goes away
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      trn_in_packet <= 1'b0;
    end else if (!trn_lnk_up) begin
      trn_in_packet <= 1'b0;
    end else if (trn_beat) begin
      trn_in_packet <= !stage_last;
    end
  end

  // First presented beat of a packet
  assign trn_tsof = trn_tsrc_rdy && !trn_in_packet;
  assign trn_teof = stage_last;

  // Lane order and remainder in TRN format
  assign trn_td = trn_dw_swap(stage_data);
  assign trn_trem = keep_to_trem(stage_keep);

  // Sideband flags travel with their beat
  assign trn_tecrc_gen = stage_user[tuser_ecrc_gen];
  assign trn_terrfwd = stage_user[tuser_err_fwd];
  assign trn_tstr = stage_user[tuser_str];
  assign trn_tsrc_dsc = stage_user[tuser_src_dsc];

endmodule

`default_nettype wire

// ==== tb/tb_pcie_tx_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pcie_tx_cfg.svh"

module tb_pcie_tx_bridge;

  localparam int dw = `PCIE_TX_DATA_WIDTH;
  localparam int kw = `PCIE_TX_KEEP_WIDTH;
  localparam int rw = `PCIE_TX_REM_WIDTH;
  localparam int dwc = dw / 32;
  // Expected word is {td, trem, sof, eof, ecrc, errfwd, str, src_dsc}
  localparam int ew = dw + rw + 6;
  localparam int beat_limit = 200;
  localparam int drain_limit = 4000;

  logic          user_clk;
  logic          user_rst;
  logic [dw-1:0] s_axis_tx_tdata;
  logic [kw-1:0] s_axis_tx_tkeep;
  logic          s_axis_tx_tlast;
  logic    [3:0] s_axis_tx_tuser;
  logic          s_axis_tx_tvalid;
  logic          s_axis_tx_tready;
  logic [dw-1:0] trn_td;
  logic          trn_tsof;
  logic          trn_teof;
  logic [rw-1:0] trn_trem;
  logic          trn_tsrc_rdy;
  logic          trn_tdst_rdy;
  logic          trn_tsrc_dsc;
  logic          trn_terrfwd;
  logic          trn_tstr;
  logic          trn_tecrc_gen;
  logic          trn_lnk_up;

  // Scoreboard state
  logic [ew-1:0] exp_q[$];
  logic          axi_in_pkt;
  logic          discard;
  logic          no_src_check;
  int            tdst_mode;
  int            accepted;
  int            checked;
  int            errors;
  int            tests_run;
  int            tests_failed;
  string         test_name;

  pcie_tx_bridge DUT (
    .user_clk         (user_clk),
    .user_rst         (user_rst),
    .s_axis_tx_tdata  (s_axis_tx_tdata),
    .s_axis_tx_tkeep  (s_axis_tx_tkeep),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tuser  (s_axis_tx_tuser),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tready (s_axis_tx_tready),
    .trn_td           (trn_td),
    .trn_tsof         (trn_tsof),
    .trn_teof         (trn_teof),
    .trn_trem         (trn_trem),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_tsrc_dsc     (trn_tsrc_dsc),
    .trn_terrfwd      (trn_terrfwd),
    .trn_tstr         (trn_tstr),
    .trn_tecrc_gen    (trn_tecrc_gen),
    .trn_lnk_up       (trn_lnk_up)
  );

  always #10 user_clk = ~user_clk;

  // Expected TRN beat for one accepted AXI beat
  function automatic logic [ew-1:0] trn_expect(
    input logic [dw-1:0] data,
    input logic [kw-1:0] keep,
    input logic    [3:0] user,
    input logic          first,
    input logic          last
  );
    logic [dw-1:0] td;
    logic [rw-1:0] trem;
    int            used_dw;
    // AXI DW j fills the j-th TRN lane counted from the top
    for (int j = 0; j < dwc; j++) begin
      td[dw-1-32*j -: 32] = data[32*j +: 32];
    end
    // Keep is filled from byte 0 in whole DWORDs
    used_dw = $countones(keep) / 4;
    trem = '0;
    if (dw == 128) begin
      // Valid DWORDs above D0
      trem = rw'(used_dw - 1);
    end else if (dw == 64) begin
      trem[0] = keep[7];
    end
    // Flags in tuser bit order
    // ecrc sits on bit 0
    return {td, trem, first, last, user[0], user[1], user[2], user[3]};
  endfunction

  // Stall pattern for trn_tdst_rdy
  // Mode 2 leaves it to the test
  always @(posedge user_clk) begin
    if (tdst_mode == 0) begin
      trn_tdst_rdy <= 1'b1;
    end else if (tdst_mode == 1) begin
      trn_tdst_rdy <= ($urandom % 3) != 0;
    end
  end

  // Compare each completed TRN beat against the oldest expected one
  // The AXI beat accepted at the same edge joins the queue afterwards
  always @(posedge user_clk) begin
    logic [ew-1:0] exp_beat;
    logic [ew-1:0] act_beat;
    if (!user_rst) begin
      assert (!(no_src_check && trn_tsrc_rdy)) else begin
        $display("%s: trn_tsrc_rdy rose while the link was down", test_name);
        errors++;
      end
      if (trn_tsrc_rdy && trn_tdst_rdy) begin
        act_beat = {trn_td, trn_trem, trn_tsof, trn_teof,
                    trn_tecrc_gen, trn_terrfwd, trn_tstr, trn_tsrc_dsc};
        assert (exp_q.size() > 0) else begin
          $display("%s: TRN beat completed with no accepted AXI beat", test_name);
          errors++;
        end
        if (exp_q.size() > 0) begin
          exp_beat = exp_q.pop_front();
          checked++;
          assert (act_beat == exp_beat) else begin
            $display("FAIL %s expected %h actual %h", test_name, exp_beat, act_beat);
            errors++;
          end
        end
      end
      // Record the AXI beat accepted at this edge
      if (s_axis_tx_tvalid && s_axis_tx_tready) begin
        accepted++;
        if (!discard) begin
          exp_q.push_back(trn_expect(s_axis_tx_tdata, s_axis_tx_tkeep, s_axis_tx_tuser,
                                     !axi_in_pkt, s_axis_tx_tlast));
        end
        axi_in_pkt = !s_axis_tx_tlast;
      end
    end
  end

  task automatic send_packet(input int len, input bit rand_user);
    logic [dw-1:0] data;
    logic [kw-1:0] keep;
    int            waited;
    int            n;
    for (int b = 0; b < len; b++) begin
      for (int i = 0; i < dwc; i++) begin
        data[32*i +: 32] = $urandom;
      end
      keep = '1;
      if (b == len - 1) begin
        // Last beat carries 1 to dwc DWORDs
        n = 1 + ($urandom % dwc);
        keep = '0;
        for (int i = 0; i < 4 * n; i++) begin
          keep[i] = 1'b1;
        end
      end
      if (b == 0) begin
        @(posedge user_clk);
      end
      s_axis_tx_tdata <= data;
      s_axis_tx_tkeep <= keep;
      s_axis_tx_tlast <= (b == len - 1);
      s_axis_tx_tuser <= rand_user ? 4'($urandom) : 4'd0;
      s_axis_tx_tvalid <= 1'b1;
      waited = 0;
      do begin
        @(posedge user_clk);
        waited++;
      end while (!s_axis_tx_tready && waited < beat_limit);
      if (waited >= beat_limit) begin
        $display("%s: AXI beat was never accepted", test_name);
        errors++;
      end
    end
    s_axis_tx_tvalid <= 1'b0;
    s_axis_tx_tlast <= 1'b0;
    repeat ($urandom % 3) @(posedge user_clk);
  endtask

  // Wait until every expected beat has come out
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(negedge user_clk);
      waited++;
    end
    if (waited >= drain_limit) begin
      $display("%s: %0d expected beats never left the bridge", test_name, exp_q.size());
      errors++;
    end
  endtask

  task automatic finish_test(input int err_start);
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", test_name, errors - err_start);
    end else begin
      $display("%s: ok", test_name);
    end
  endtask

  initial begin
    int err_start;
    int base;
    int waited;
    void'($urandom(32'h3a5b));
    user_clk = 1'b0;
    user_rst = 1'b1;
    s_axis_tx_tdata = '0;
    s_axis_tx_tkeep = '0;
    s_axis_tx_tlast = 1'b0;
    s_axis_tx_tuser = 4'd0;
    s_axis_tx_tvalid = 1'b0;
    trn_tdst_rdy = 1'b1;
    trn_lnk_up = 1'b1;
    axi_in_pkt = 1'b0;
    discard = 1'b0;
    no_src_check = 1'b0;
    tdst_mode = 0;
    accepted = 0;
    checked = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "reset";
    repeat (16) @(posedge user_clk);
    user_rst <= 1'b0;

    // Idle after reset
    test_name = "test5_idle";
    err_start = errors;
    repeat (12) begin
      @(negedge user_clk);
      assert (!trn_tsrc_rdy) else begin
        $display("%s: trn_tsrc_rdy high with no beat offered", test_name);
        errors++;
      end
    end
    finish_test(err_start);

    test_name = "test1_stream";
    err_start = errors;
    repeat (12) send_packet(1 + $urandom % 6, 1'b0);
    wait_drain();
    finish_test(err_start);

    test_name = "test2_stall";
    err_start = errors;
    tdst_mode = 1;
    repeat (12) send_packet(1 + $urandom % 6, 1'b0);
    wait_drain();
    tdst_mode = 0;
    finish_test(err_start);

    test_name = "test3_tuser";
    err_start = errors;
    repeat (10) send_packet(1 + $urandom % 5, 1'b1);
    wait_drain();
    finish_test(err_start);

    // Link drop in the middle of a stalled packet
    test_name = "test4_link_drop";
    err_start = errors;
    tdst_mode = 2;
    base = accepted;
    fork
      send_packet(8, 1'b1);
      begin
        waited = 0;
        while (accepted < base + 2 && waited < beat_limit) begin
          @(negedge user_clk);
          waited++;
        end
        if (waited >= beat_limit) begin
          $display("%s: packet start was never accepted", test_name);
          errors++;
        end
        @(posedge user_clk);
        trn_tdst_rdy <= 1'b0;
        repeat (2) @(posedge user_clk);
        trn_lnk_up <= 1'b0;
        @(negedge user_clk);
        discard = 1'b1;
        exp_q.delete();
        repeat (2) @(posedge user_clk);
        @(negedge user_clk);
        no_src_check = 1'b1;
        @(posedge user_clk);
        trn_tdst_rdy <= 1'b1;
      end
    join
    repeat (3) @(posedge user_clk);
    @(negedge user_clk);
    no_src_check = 1'b0;
    discard = 1'b0;
    @(posedge user_clk);
    trn_lnk_up <= 1'b1;
    tdst_mode = 0;
    repeat (4) @(posedge user_clk);
    send_packet(4, 1'b1);
    wait_drain();
    finish_test(err_start);

    $display("tests %0d, failed %0d, beats checked %0d, errors %0d",
             tests_run, tests_failed, checked, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
